//--- files.f
+incdir+sim
rtl/jesd_link_pkg.sv
rtl/jesd_state_pkg.sv
rtl/lane_ctrl_if.sv
rtl/rx_lmfc.sv
rtl/rx_ctrl.sv
rtl/rx_lane.sv
rtl/rx_frame_mark.sv
rtl/jesd_rx_top.sv
sim/tb_jesd_rx.sv

//--- rtl/jesd_link_pkg.sv
package jesd_link_pkg;

  // ********************************************************************
  // Link format
  // ********************************************************************

  localparam int NUM_LANES       = 2;
  localparam int OCTETS_PER_BEAT = 4;

  localparam logic [7:0] K28_5 = 8'hBC;  // Comma used during CGS

  localparam int CGS_LOCK_BEATS = 4;
  localparam int CGS_LOSS_BEATS = 4;

  // Largest multiframe in beats, also the elastic buffer depth
  localparam int MAX_BEATS_PER_MF = 32;

  // ********************************************************************
  // Vector types
  // ********************************************************************

  // One lane's beat, octet 0 in the low byte
  typedef logic [8*OCTETS_PER_BEAT-1:0] beat_t;

  // One flag per octet of a beat
  typedef logic [OCTETS_PER_BEAT-1:0] char_flags_t;

  typedef logic [$clog2(MAX_BEATS_PER_MF)-1:0] lmfc_cnt_t;

  typedef logic [31:0] err_cnt_t;

  typedef logic [NUM_LANES-1:0] lane_mask_t;

endpackage

//--- rtl/jesd_rx_top.sv
module jesd_rx_top
  import jesd_link_pkg::*;
  import jesd_state_pkg::*;
(
  input  logic                                    clk,
  input  logic                                    device_reset,
  input  logic [NUM_LANES*$bits(beat_t)-1:0]      i_phy_data,
  input  logic [NUM_LANES*OCTETS_PER_BEAT-1:0]    i_phy_charisk,
  input  logic [NUM_LANES*OCTETS_PER_BEAT-1:0]    i_phy_notintable,
  input  logic [NUM_LANES*OCTETS_PER_BEAT-1:0]    i_phy_disperr,
  input  logic                                    i_sysref,
  input  lane_mask_t                              i_cfg_lanes_disable,
  input  lmfc_cnt_t                               i_cfg_beats_per_mf,
  input  lmfc_cnt_t                               i_cfg_lmfc_offset,
  input  logic [1:0]                              i_cfg_octets_per_frame,
  input  logic                                    i_cfg_sysref_oneshot,
  input  lmfc_cnt_t                               i_cfg_buffer_delay,
  input  logic                                    i_cfg_early_release,
  input  logic                                    i_err_stats_reset,
  input  logic [1:0]                              i_err_mask,
  output logic                                    o_sync,
  output logic                                    o_lmfc_edge,
  output logic                                    o_sysref_alignment_error,
  output logic                                    o_event_unexpected_lane_state,
  output logic [NUM_LANES*$bits(beat_t)-1:0]      o_rx_data,
  output logic                                    o_rx_valid,
  output char_flags_t                             o_rx_sof,
  output char_flags_t                             o_rx_eof,
  output char_flags_t                             o_rx_somf,
  output char_flags_t                             o_rx_eomf,
  output ctrl_state_t                             o_status_ctrl_state,
  output logic [2*NUM_LANES-1:0]                  o_status_cgs_state,
  output logic [NUM_LANES*$bits(err_cnt_t)-1:0]   o_err_cnt
);

  lane_ctrl_if lane_ctl ();

  lmfc_cnt_t lmfc_counter;
  logic      lmfc_edge;
  logic      data_phase_start;
  logic      err_reset;
  logic      release_opp;
  logic      buffer_release;
  logic      rx_valid_q;

  // ********************************************************************
  // Buffer release
  // ********************************************************************

  always_ff @(posedge clk) begin
    if (device_reset) begin
      release_opp    <= 1'b0;
      buffer_release <= 1'b0;
      rx_valid_q     <= 1'b0;
    end else begin
      release_opp <= (lmfc_counter == i_cfg_buffer_delay) || i_cfg_early_release;
      if (release_opp) begin
        buffer_release <= &(lane_ctl.buffer_ready | i_cfg_lanes_disable);
      end
      rx_valid_q <= buffer_release;  // Lane data is one register behind release
    end
  end

  assign err_reset = i_err_stats_reset | data_phase_start;

  rx_lmfc u_lmfc (
    .clk                      (clk),
    .device_reset             (device_reset),
    .i_sysref                 (i_sysref),
    .i_cfg_beats_per_mf       (i_cfg_beats_per_mf),
    .i_cfg_lmfc_offset        (i_cfg_lmfc_offset),
    .i_cfg_sysref_oneshot     (i_cfg_sysref_oneshot),
    .o_lmfc_edge              (lmfc_edge),
    .o_lmfc_counter           (lmfc_counter),
    .o_sysref_alignment_error (o_sysref_alignment_error)
  );

  rx_ctrl u_ctrl (
    .clk                           (clk),
    .device_reset                  (device_reset),
    .lanes                         (lane_ctl),
    .i_cfg_lanes_disable           (i_cfg_lanes_disable),
    .i_lmfc_edge                   (lmfc_edge),
    .o_sync                        (o_sync),
    .o_status_state                (o_status_ctrl_state),
    .o_event_unexpected_lane_state (o_event_unexpected_lane_state),
    .o_data_phase_start            (data_phase_start)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    beat_t      lane_data;
    cgs_state_t lane_state;

    rx_lane #(.LANE(i)) u_lane (
      .clk              (clk),
      .device_reset     (device_reset),
      .ctl              (lane_ctl),
      .i_data           (i_phy_data[i*$bits(beat_t) +: $bits(beat_t)]),
      .i_charisk        (i_phy_charisk[i*OCTETS_PER_BEAT +: OCTETS_PER_BEAT]),
      .i_notintable     (i_phy_notintable[i*OCTETS_PER_BEAT +: OCTETS_PER_BEAT]),
      .i_disperr        (i_phy_disperr[i*OCTETS_PER_BEAT +: OCTETS_PER_BEAT]),
      .i_buffer_release (buffer_release),
      .i_err_reset      (err_reset),
      .i_err_mask       (i_err_mask),
      .o_data           (lane_data),
      .o_cgs_state      (lane_state),
      .o_err_cnt        (o_err_cnt[i*$bits(err_cnt_t) +: $bits(err_cnt_t)])
    );

    assign o_rx_data[i*$bits(beat_t) +: $bits(beat_t)] =
      i_cfg_lanes_disable[i] ? '0 : lane_data;
    assign o_status_cgs_state[2*i +: 2] = lane_state;
  end

  rx_frame_mark u_frame_mark (
    .clk                    (clk),
    .device_reset           (device_reset),
    .i_rx_valid             (rx_valid_q),
    .i_cfg_octets_per_frame (i_cfg_octets_per_frame),
    .i_cfg_beats_per_mf     (i_cfg_beats_per_mf),
    .o_sof                  (o_rx_sof),
    .o_eof                  (o_rx_eof),
    .o_somf                 (o_rx_somf),
    .o_eomf                 (o_rx_eomf)
  );

  assign o_lmfc_edge = lmfc_edge;
  assign o_rx_valid  = rx_valid_q;

endmodule

//--- rtl/jesd_state_pkg.sv
package jesd_state_pkg;

  // ********************************************************************
  // Link controller
  // ********************************************************************

  // DATA is 3 so that the status word reads all ones in data phase
  typedef enum logic [1:0] {
    CTRL_RESET = 2'd0,
    CTRL_CGS   = 2'd1,
    CTRL_DATA  = 2'd3
  } ctrl_state_t;

  // ********************************************************************
  // Lane code group synchronization
  // ********************************************************************

  typedef enum logic [1:0] {
    CGS_INIT  = 2'd0,  // Hunting for commas
    CGS_CHECK = 2'd1,  // Locked, waiting for first data
    CGS_DATA  = 2'd2
  } cgs_state_t;

endpackage

//--- rtl/lane_ctrl_if.sv
interface lane_ctrl_if
  import jesd_link_pkg::*;
();

  lane_mask_t cgs_reset;     // Controller holds lanes in CGS_INIT
  lane_mask_t ifs_reset;     // Controller holds buffers empty
  lane_mask_t cgs_ready;
  lane_mask_t buffer_ready;  // Lane has written at least one beat

  modport ctrl (output cgs_reset, output ifs_reset, input cgs_ready);

  modport lane (input cgs_reset, input ifs_reset, output cgs_ready, output buffer_ready);

  // Release logic only watches the buffers
  modport rel (input buffer_ready);

endinterface

//--- rtl/rx_ctrl.sv
module rx_ctrl
  import jesd_link_pkg::*;
  import jesd_state_pkg::*;
(
  input  logic          clk,
  input  logic          device_reset,
  lane_ctrl_if.ctrl     lanes,
  input  lane_mask_t    i_cfg_lanes_disable,
  input  logic          i_lmfc_edge,
  output logic          o_sync,
  output ctrl_state_t   o_status_state,
  output logic          o_event_unexpected_lane_state,
  output logic          o_data_phase_start
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic        all_ready;
  logic        any_drop;
  logic        go_data;
  logic        event_q;
  logic        phase_start_q;

  // Disabled lanes count as ready and never as dropped
  assign all_ready = &(lanes.cgs_ready | i_cfg_lanes_disable);
  assign any_drop  = |(~lanes.cgs_ready & ~i_cfg_lanes_disable);

  assign go_data = (state == CTRL_CGS) && i_lmfc_edge && all_ready;

  always_comb begin
    state_next = state;
    case (state)
      CTRL_RESET: begin
        state_next = CTRL_CGS;
      end
      CTRL_CGS: begin
        if (go_data) begin
          state_next = CTRL_DATA;
        end
      end
      CTRL_DATA: begin
        if (any_drop) begin
          state_next = CTRL_CGS;
        end
      end
      default: begin
        state_next = CTRL_RESET;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (device_reset) begin
      state         <= CTRL_RESET;
      event_q       <= 1'b0;
      phase_start_q <= 1'b0;
    end else begin
      state         <= state_next;
      event_q       <= (state == CTRL_DATA) && any_drop;
      phase_start_q <= go_data;
    end
  end

  // ********************************************************************
  // Lane controls and link status
  // ********************************************************************

  assign lanes.cgs_reset = {NUM_LANES{state == CTRL_RESET}};
  assign lanes.ifs_reset = {NUM_LANES{state != CTRL_DATA}};  // Buffers fill only in data phase

  assign o_sync                        = (state == CTRL_DATA);
  assign o_status_state                = state;
  assign o_event_unexpected_lane_state = event_q;
  assign o_data_phase_start            = phase_start_q;

  // SYNC may only rise on the beat after a multiframe boundary
  a_sync_on_lmfc : assert property (
    @(posedge clk) disable iff (device_reset)
    $rose(o_sync) |-> $past(i_lmfc_edge)
  ) else $error("SYNC rose away from an LMFC edge");

endmodule

//--- rtl/rx_frame_mark.sv
module rx_frame_mark
  import jesd_link_pkg::*;
(
  input  logic        clk,
  input  logic        device_reset,
  input  logic        i_rx_valid,
  input  logic [1:0]  i_cfg_octets_per_frame,  // log2 of F, so 0, 1 or 2
  input  lmfc_cnt_t   i_cfg_beats_per_mf,
  output char_flags_t o_sof,
  output char_flags_t o_eof,
  output char_flags_t o_somf,
  output char_flags_t o_eomf
);

  lmfc_cnt_t   beat_n;    // Beat index inside the multiframe
  lmfc_cnt_t   beat_last;
  logic [1:0]  octet_mask;
  char_flags_t sof_pat;
  char_flags_t eof_pat;

  assign beat_last = i_cfg_beats_per_mf - 1'b1;

  always_comb begin
    case (i_cfg_octets_per_frame)
      2'd0:    octet_mask = 2'b00;
      2'd1:    octet_mask = 2'b01;
      default: octet_mask = 2'b11;
    endcase
    // F divides the beat, so the pattern repeats every beat
    for (int j = 0; j < OCTETS_PER_BEAT; j++) begin
      sof_pat[j] = ((2'(j) & octet_mask) == 2'b00);
      eof_pat[j] = ((2'(j) & octet_mask) == octet_mask);
    end
  end

  always_ff @(posedge clk) begin
    if (device_reset || !i_rx_valid) begin
      beat_n <= '0;
    end else begin
      beat_n <= (beat_n == beat_last) ? '0 : beat_n + 1'b1;
    end
  end

  assign o_sof  = i_rx_valid ? sof_pat : '0;
  assign o_eof  = i_rx_valid ? eof_pat : '0;
  assign o_somf = {3'b000, i_rx_valid && (beat_n == '0)};
  assign o_eomf = {i_rx_valid && (beat_n == beat_last), 3'b000};

endmodule

//--- rtl/rx_lane.sv
module rx_lane
  import jesd_link_pkg::*;
  import jesd_state_pkg::*;
#(
  parameter int LANE = 0
) (
  input  logic        clk,
  input  logic        device_reset,
  lane_ctrl_if.lane   ctl,
  input  beat_t       i_data,
  input  char_flags_t i_charisk,
  input  char_flags_t i_notintable,
  input  char_flags_t i_disperr,
  input  logic        i_buffer_release,
  input  logic        i_err_reset,
  input  logic [1:0]  i_err_mask,  // Bit 0 disparity, bit 1 not-in-table
  output beat_t       o_data,
  output cgs_state_t  o_cgs_state,
  output err_cnt_t    o_err_cnt
);

  cgs_state_t state;
  logic [2:0] beat_cnt;   // Consecutive comma or errored beats
  logic       all_comma;
  logic       any_nit;
  logic       data_start;
  logic       buf_wr;
  logic       buf_ready_q;
  logic [$bits(lmfc_cnt_t):0] wr_ptr;  // One extra bit tells full from empty
  logic [$bits(lmfc_cnt_t):0] rd_ptr;
  logic [$bits(lmfc_cnt_t):0] buf_level;
  beat_t      buf_mem [MAX_BEATS_PER_MF];
  beat_t      data_q;
  logic [3:0] err_inc;
  err_cnt_t   err_cnt;

  always_comb begin
    all_comma = (&i_charisk) & ~(|i_notintable) & ~(|i_disperr);
    err_inc   = '0;
    for (int j = 0; j < OCTETS_PER_BEAT; j++) begin
      if (i_data[8*j +: 8] != K28_5) begin
        all_comma = 1'b0;
      end
      err_inc = err_inc + {3'b000, i_disperr[j] & ~i_err_mask[0]}
                        + {3'b000, i_notintable[j] & ~i_err_mask[1]};
    end
  end

  assign any_nit    = |i_notintable;
  assign data_start = (state == CGS_CHECK) && ~(&i_charisk) && ~ctl.ifs_reset[LANE];
  assign buf_wr     = ~ctl.ifs_reset[LANE] && (data_start || state == CGS_DATA);

  // ********************************************************************
  // Code group synchronization
  // ********************************************************************

  always_ff @(posedge clk) begin
    if (device_reset || ctl.cgs_reset[LANE]) begin
      state    <= CGS_INIT;
      beat_cnt <= '0;
    end else begin
      case (state)
        CGS_INIT: begin
          if (!all_comma) begin
            beat_cnt <= '0;
          end else if (beat_cnt == CGS_LOCK_BEATS - 1) begin
            state    <= CGS_CHECK;
            beat_cnt <= '0;
          end else begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        CGS_CHECK: begin
          if (data_start) begin
            state <= CGS_DATA;
          end
        end
        CGS_DATA: begin
          if (!any_nit) begin
            beat_cnt <= '0;
          end else if (beat_cnt == CGS_LOSS_BEATS - 1) begin
            state    <= CGS_INIT;  // Lost lock
            beat_cnt <= '0;
          end else begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        default: begin
          state <= CGS_INIT;
        end
      endcase
    end
  end

  // ********************************************************************
  // Elastic buffer
  // ********************************************************************

  always_ff @(posedge clk) begin
    if (device_reset || ctl.ifs_reset[LANE]) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      buf_ready_q <= 1'b0;
    end else begin
      if (buf_wr) begin
        wr_ptr      <= wr_ptr + 1'b1;
        buf_ready_q <= 1'b1;
      end
      if (i_buffer_release) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (buf_wr) begin
      buf_mem[wr_ptr[$bits(lmfc_cnt_t)-1:0]] <= i_data;
    end
    if (i_buffer_release) begin
      data_q <= buf_mem[rd_ptr[$bits(lmfc_cnt_t)-1:0]];
    end
  end

  assign buf_level = wr_ptr - rd_ptr;

  // Error statistics, counted in data phase only
  always_ff @(posedge clk) begin
    if (device_reset || i_err_reset) begin
      err_cnt <= '0;
    end else if (state == CGS_DATA) begin
      err_cnt <= err_cnt + err_cnt_t'(err_inc);
    end
  end

  assign ctl.cgs_ready[LANE]    = (state != CGS_INIT);
  assign ctl.buffer_ready[LANE] = buf_ready_q;

  assign o_data      = data_q;
  assign o_cgs_state = state;
  assign o_err_cnt   = err_cnt;

  // Release has to come within one buffer depth of the first write
  a_no_overflow : assert property (
    @(posedge clk) disable iff (device_reset || ctl.ifs_reset[LANE])
    buf_wr |-> (buf_level < MAX_BEATS_PER_MF)
  ) else $error("Lane %0d elastic buffer overflow", LANE);

endmodule

//--- rtl/rx_lmfc.sv
module rx_lmfc
  import jesd_link_pkg::*;
(
  input  logic      clk,
  input  logic      device_reset,
  input  logic      i_sysref,
  input  lmfc_cnt_t i_cfg_beats_per_mf,  // 0 means MAX_BEATS_PER_MF
  input  lmfc_cnt_t i_cfg_lmfc_offset,
  input  logic      i_cfg_sysref_oneshot,
  output logic      o_lmfc_edge,
  output lmfc_cnt_t o_lmfc_counter,
  output logic      o_sysref_alignment_error
);

  lmfc_cnt_t lmfc_cnt;
  lmfc_cnt_t cnt_last;
  lmfc_cnt_t cnt_inc;
  lmfc_cnt_t cnt_next;
  logic      sysref_d;
  logic      sysref_seen;
  logic      sysref_take;
  logic      edge_q;
  logic      align_err_q;

  assign cnt_last = i_cfg_beats_per_mf - 1'b1;  // A count of 0 wraps to the full range

  // Rising edge, ignored after the first one in oneshot mode
  assign sysref_take = i_sysref & ~sysref_d & ~(i_cfg_sysref_oneshot & sysref_seen);

  always_comb begin
    cnt_inc  = (lmfc_cnt == cnt_last) ? '0 : lmfc_cnt + 1'b1;
    cnt_next = sysref_take ? i_cfg_lmfc_offset : cnt_inc;
  end

  always_ff @(posedge clk) begin
    if (device_reset) begin
      lmfc_cnt    <= '0;
      sysref_d    <= 1'b0;
      sysref_seen <= 1'b0;
      edge_q      <= 1'b0;
      align_err_q <= 1'b0;
    end else begin
      lmfc_cnt <= cnt_next;
      sysref_d <= i_sysref;
      edge_q   <= (cnt_next == '0);
      // A later edge that lands off the running phase
      align_err_q <= sysref_take & sysref_seen & (cnt_inc != i_cfg_lmfc_offset);
      if (sysref_take) begin
        sysref_seen <= 1'b1;
      end
    end
  end

  assign o_lmfc_edge              = edge_q;
  assign o_lmfc_counter           = lmfc_cnt;
  assign o_sysref_alignment_error = align_err_q;

  // ********************************************************************
  // Checks
  // ********************************************************************

  // Offset has to fall inside the multiframe or the edge never lines up
  a_offset_in_range : assert property (
    @(posedge clk) disable iff (device_reset)
    (i_cfg_beats_per_mf == '0) || (i_cfg_lmfc_offset < i_cfg_beats_per_mf)
  ) else $error("LMFC offset %0d outside multiframe of %0d beats",
                i_cfg_lmfc_offset, i_cfg_beats_per_mf);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run with Verilator, result taken from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_jesd_rx \
  -o tb_jesd_rx > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_jesd_rx > sim.log 2>&1 || true
grep -q "SIMULATION FAILED" sim.log && { echo "Test failed, see sim.log"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "No result in sim.log"; exit 1; }
echo "Test passed"

//--- sim/tb_lane_model.svh
// ********************************************************************
// Payload generator
// ********************************************************************

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

// One step per payload bit taken
task automatic next_payload(output beat_t w);
  for (int b = 0; b < 32; b++) begin
    lfsr_state = lfsr_step(lfsr_state);
    w[b]       = lfsr_state[0];
  end
endtask

// Expected {sof, eof, somf, eomf} for valid beat n
function automatic logic [15:0] ref_marks(input int n);
  char_flags_t sof;
  char_flags_t eof;
  char_flags_t somf;
  char_flags_t eomf;
  for (int j = 0; j < 4; j++) begin
    sof[j] = ((4 * n + j) % FRAME_OCTETS) == 0;
    eof[j] = ((4 * n + j) % FRAME_OCTETS) == FRAME_OCTETS - 1;
  end
  somf = ((n % BEATS) == 0) ? 4'b0001 : 4'b0000;
  eomf = ((n % BEATS) == BEATS - 1) ? 4'b1000 : 4'b0000;
  return {sof, eof, somf, eomf};
endfunction

task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
  if (exp !== act) begin
    $display("error %s expected %0h actual %0h", name, exp, act);
    abort_run();
  end
endtask

// Commas until a lane switches to payload, flags applied on top
task automatic drive_lanes();
  beat_t                 w;
  logic [63:0]           data;
  logic [7:0]            isk;
  logic [7:0]            nit;
  logic [7:0]            disp;
  data = '0;
  isk  = '0;
  nit  = '0;
  disp = '0;
  for (int l = 0; l < 2; l++) begin
    if (data_mode[l]) begin
      next_payload(w);
      if (l == 0) exp_q0.push_back(w);
      else exp_q1.push_back(w);
      data[32*l +: 32] = w;
    end else begin
      data[32*l +: 32] = {4{K28_5}};
      isk[4*l +: 4]    = 4'hF;
    end
    disp[4*l +: 4] = disp_once[l];
    disp_once[l]   = '0;
    if (nit_left[l] > 0) begin
      nit[4*l +: 4] = 4'b0001;
      nit_left[l]   = nit_left[l] - 1;
    end
  end
  i_phy_data       = data;
  i_phy_charisk    = isk;
  i_phy_notintable = nit;
  i_phy_disperr    = disp;
endtask

//--- sim/tb_jesd_rx.sv
module tb_jesd_rx
  import jesd_link_pkg::*;
  import jesd_state_pkg::*;
();

  localparam int BEATS         = 8;
  localparam int OFFSET        = 3;
  localparam int FRAME_OCTETS  = 2;
  localparam int COMPARE_BEATS = 40;

  logic        clk;
  logic        device_reset;
  logic [63:0] i_phy_data;
  logic [7:0]  i_phy_charisk;
  logic [7:0]  i_phy_notintable;
  logic [7:0]  i_phy_disperr;
  logic        i_sysref;
  lane_mask_t  i_cfg_lanes_disable;
  lmfc_cnt_t   i_cfg_beats_per_mf;
  lmfc_cnt_t   i_cfg_lmfc_offset;
  logic [1:0]  i_cfg_octets_per_frame;
  logic        i_cfg_sysref_oneshot;
  lmfc_cnt_t   i_cfg_buffer_delay;
  logic        i_cfg_early_release;
  logic        i_err_stats_reset;
  logic [1:0]  i_err_mask;
  logic        o_sync;
  logic        o_lmfc_edge;
  logic        o_sysref_alignment_error;
  logic        o_event_unexpected_lane_state;
  logic [63:0] o_rx_data;
  logic        o_rx_valid;
  char_flags_t o_rx_sof;
  char_flags_t o_rx_eof;
  char_flags_t o_rx_somf;
  char_flags_t o_rx_eomf;
  ctrl_state_t o_status_ctrl_state;
  logic [3:0]  o_status_cgs_state;
  logic [63:0] o_err_cnt;

  logic [31:0] lfsr_state = 32'h79c5_2b91;
  beat_t       exp_q0[$];
  beat_t       exp_q1[$];
  logic [1:0]  data_mode;  // 1 sends payload on that lane
  char_flags_t disp_once [2];
  int          nit_left [2];
  int          n_valid;
  int          align_errs;
  int          lane_events;
  int          errors;
  int          k;
  int          n;

  jesd_rx_top dut (.*);

  `include "tb_lane_model.svh"

  always #50 clk = ~clk;

  task automatic abort_run();
    errors++;
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    abort_run();
  endtask

  always @(posedge clk) begin
    #10;
    drive_lanes();
  end

  // ********************************************************************
  // Output compare and event counters
  // ********************************************************************

  always @(negedge clk) begin
    if (!device_reset && o_rx_valid && n_valid < COMPARE_BEATS) begin
      if (exp_q0.size() == 0 || exp_q1.size() == 0) begin
        report_failure("valid output beat with no payload beat driven for it");
      end
      check_value("rx_data", {exp_q1.pop_front(), exp_q0.pop_front()}, o_rx_data);
      check_value("frame_marks", ref_marks(n_valid), {o_rx_sof, o_rx_eof, o_rx_somf, o_rx_eomf});
      n_valid++;
    end else if (!device_reset && !o_rx_valid) begin
      check_value("idle_frame_marks", 0, {o_rx_sof, o_rx_eof, o_rx_somf, o_rx_eomf});
    end
    if (o_sysref_alignment_error) align_errs++;
    if (o_event_unexpected_lane_state) lane_events++;
  end

  // Offset m of the SYSREF sample after an LMFC edge
  task automatic sysref_after_edge(input int m);
    int t;
    t = 0;
    do begin
      @(negedge clk);
      t++;
      if (t > 4 * BEATS) report_failure("timeout waiting for an LMFC edge");
    end while (!o_lmfc_edge);
    repeat (m - 1) @(posedge clk);
    #10 i_sysref = 1'b1;
    @(posedge clk);
    #10 i_sysref = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    device_reset = 1'b1;
    i_phy_data = '0;
    i_phy_charisk = '0;
    i_phy_notintable = '0;
    i_phy_disperr = '0;
    i_sysref = 1'b0;
    i_cfg_lanes_disable = '0;
    i_cfg_beats_per_mf = lmfc_cnt_t'(BEATS);
    i_cfg_lmfc_offset = lmfc_cnt_t'(OFFSET);
    i_cfg_octets_per_frame = 2'd1;  // F = 2
    i_cfg_sysref_oneshot = 1'b0;
    i_cfg_buffer_delay = 5'd5;
    i_cfg_early_release = 1'b0;
    i_err_stats_reset = 1'b0;
    i_err_mask = 2'b00;
    data_mode = '0;
    disp_once[0] = '0;
    disp_once[1] = '0;
    nit_left[0] = 0;
    nit_left[1] = 0;
    n_valid = 0;
    align_errs = 0;
    lane_events = 0;
    errors = 0;
    repeat (5) @(posedge clk);
    #10 device_reset = 1'b0;
    @(negedge clk);
    check_value("sync_after_reset", 0, o_sync);
    check_value("valid_after_reset", 0, o_rx_valid);
    check_value("lmfc_edge_after_reset", 0, o_lmfc_edge);
    check_value("align_err_after_reset", 0, o_sysref_alignment_error);
    check_value("lane_event_after_reset", 0, o_event_unexpected_lane_state);

    // ****************************************************************
    // LMFC alignment and link bring-up
    // ****************************************************************
    @(posedge clk);
    #10 i_sysref = 1'b1;
    @(posedge clk);
    #10 i_sysref = 1'b0;
    k = 0;
    do begin
      @(negedge clk);
      k++;
      if (k > 4 * BEATS) report_failure("timeout waiting for the first LMFC edge");
    end while (!o_lmfc_edge);
    check_value("first_lmfc_edge", 1 + ((BEATS - OFFSET) % BEATS), k);
    n = k;  // Cycles since the SYSREF sample
    k = 0;
    do begin
      @(negedge clk);
      k++;
      if (k > 4 * BEATS) report_failure("timeout waiting for the next LMFC edge");
    end while (!o_lmfc_edge);
    check_value("lmfc_period", BEATS, k);
    n = n + k;
    while (!o_sync) begin
      @(negedge clk);
      n++;
      if (n > 2 * BEATS) report_failure("SYNC did not rise within two multiframes");
    end
    check_value("ctrl_state", 3, o_status_ctrl_state);
    check_value("cgs_state_locked", {CGS_CHECK, CGS_CHECK}, o_status_cgs_state);
    n = align_errs;
    sysref_after_edge(OFFSET);
    repeat (10) @(negedge clk);
    check_value("aligned_sysref_errors", n, align_errs);
    sysref_after_edge(OFFSET + 2);
    repeat (10) @(negedge clk);
    check_value("misaligned_sysref_errors", n + 1, align_errs);

    // Lane 1 runs three beats late and the buffers deskew it
    @(negedge clk);
    data_mode[0] = 1'b1;
    repeat (3) @(negedge clk);
    data_mode[1] = 1'b1;
    k = 0;
    while (n_valid < COMPARE_BEATS) begin
      @(negedge clk);
      k++;
      if (k > 200) report_failure("timeout waiting for released lane data");
    end
    check_value("cgs_state_data", {CGS_DATA, CGS_DATA}, o_status_cgs_state);

    // ****************************************************************
    // Error counting
    // ****************************************************************
    @(negedge clk);
    disp_once[0] = 4'b0111;
    k = 0;
    while (o_err_cnt[31:0] == 0) begin
      @(negedge clk);
      k++;
      if (k > 10) report_failure("timeout waiting for the lane 0 error count");
    end
    check_value("err_cnt", {32'd0, 32'd3}, o_err_cnt);
    @(posedge clk);
    #10 i_err_mask = 2'b01;
    @(negedge clk);
    disp_once[0] = 4'b1011;
    repeat (4) @(negedge clk);
    check_value("err_cnt_masked", {32'd0, 32'd3}, o_err_cnt);
    @(posedge clk);
    #10 i_err_stats_reset = 1'b1;
    @(posedge clk);
    #10 i_err_stats_reset = 1'b0;
    i_err_mask = 2'b00;
    @(negedge clk);
    check_value("err_cnt_cleared", 0, o_err_cnt);

    // Lane 1 loses lock while enabled and then while disabled
    nit_left[1] = 4;
    k = 0;
    do begin
      @(negedge clk);
      k++;
      if (k > 20) report_failure("timeout waiting for the unexpected lane event");
    end while (!o_event_unexpected_lane_state);
    check_value("sync_after_drop", 0, o_sync);
    check_value("cgs_state_drop", {CGS_INIT, CGS_DATA}, o_status_cgs_state);
    data_mode[1] = 1'b0;
    k = 0;
    while (!o_sync) begin
      @(negedge clk);
      k++;
      if (k > 4 * BEATS) report_failure("timeout waiting for SYNC after relock");
    end
    @(posedge clk);
    #10 i_cfg_lanes_disable = 2'b10;
    @(negedge clk);
    data_mode[1] = 1'b1;
    repeat (3) @(negedge clk);
    n = lane_events;
    nit_left[1] = 4;
    repeat (12) begin
      @(negedge clk);
      check_value("sync_disabled_lane", 1, o_sync);
      check_value("disabled_lane_data", 0, o_rx_data[63:32]);
    end
    check_value("disabled_lane_events", n, lane_events);

    if (errors == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

endmodule
